//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module screenManager_tb
	out=$$(./obj_dir/VscreenManager_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

//--- bench/screenManager_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_defs.svh"

module screenManager_props (
	input logic clk,
	input logic rstN,
	input logic sampleValid,
	input logic [`NUM_BANDS-1:0] bandEnable,
	input spectrumPkg::rgb_t colour,
	input logic [`POWER_W-1:0] power [`NUM_BANDS]
);
	import spectrumPkg::*;

	// output register clears under reset
	blackAfterReset: assert property (@(posedge clk) !rstN |=> (colour == BLACK))
		else $error("colour is not black in the cycle after reset");

	// only black, green, yellow and red ever reach the screen
	paletteOnly: assert property (@(posedge clk) disable iff (!rstN)
		(colour == 24'h000000 || colour == 24'h00ff00 || colour == 24'hffff00
			|| colour == 24'hff0000))
		else $error("colour %h is outside the palette", colour);

	// power moves only after a strobe, or when its enable toggles
	for (genvar b = 0; b < `NUM_BANDS; b++) begin : powerGen
		powerOnStrobe: assert property (@(posedge clk) disable iff (!rstN)
			(!$past(sampleValid) && $stable(bandEnable[b])) |-> $stable(power[b]))
			else $error("band %0d power changed without a strobe", b);
	end

endmodule

`default_nettype wire

//--- bench/screenManager_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_defs.svh"

module screenManager_tb;
	import spectrumPkg::*;

	localparam int DRAIN_LIMIT = 20;
	// filter precision below the sample LSB
	localparam int FILTER_FRAC = 8;
	localparam int POWER_CAP = 2047;

	typedef struct packed {
		logic [9:0] x;
		logic [8:0] y;
		logic [23:0] colour;
	} expect_t;

	logic clk = 1'b0;
	logic rstN;
	logic sampleValid;
	sample_t audioL;
	sample_t audioR;
	logic [`NUM_BANDS-1:0] bandEnable;
	pixelPos_t pixel;
	rgb_t colour;

	// tag follows each pixel through the two-stage pipeline
	logic pixTag;
	logic tagD1 = 1'b0;
	logic tagD2 = 1'b0;
	expect_t expQ [$];

	int errorCount = 0;
	int checkCount = 0;
	bit timedOut = 1'b0;
	logic [15:0] lfsr;

	// model state per band
	longint fastM [`NUM_BANDS];
	longint slowM [`NUM_BANDS];
	int envM [`NUM_BANDS];
	logic [`NUM_BANDS-1:0] enableM;

	screenManager screenManager_inst (
		.clk(clk),
		.rstN(rstN),
		.sampleValid(sampleValid),
		.audioL(audioL),
		.audioR(audioR),
		.bandEnable(bandEnable),
		.pixel(pixel),
		.colour(colour)
	);

	bind screenManager screenManager_props screenManager_props_inst (
		.clk(clk),
		.rstN(rstN),
		.sampleValid(sampleValid),
		.bandEnable(bandEnable),
		.colour(colour),
		.power(power)
	);

	always #5 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// uniform in -4096..4095
	task automatic randomSample(output int v);
		logic [31:0] bits;
		drawBits(13, bits);
		v = int'(bits[12:0]) - 4096;
	endtask

	// one strobe through the band model
	function automatic void modelSample(input int l, input int r);
		longint mono;
		longint bp;
		int bpInt;
		int decayed;
		int fs;
		int ss;
		mono = longint'((l + r) >>> 1);
		for (int b = 0; b < `NUM_BANDS; b++) begin
			fs = b + `FAST_SHIFT_BASE;
			ss = fs + `SLOW_SHIFT_GAP;
			if (!enableM[b]) begin
				fastM[b] = 0;
				slowM[b] = 0;
				envM[b] = 0;
			end else begin
				fastM[b] = fastM[b] + (((mono << FILTER_FRAC) - fastM[b]) >>> fs);
				slowM[b] = slowM[b] + (((mono << FILTER_FRAC) - slowM[b]) >>> ss);
				bp = fastM[b] - slowM[b];
				if (bp < 0) begin
					bp = -bp;
				end
				bpInt = int'(bp >>> FILTER_FRAC);
				if (bpInt > POWER_CAP) begin
					bpInt = POWER_CAP;
				end
				decayed = envM[b] - (envM[b] >>> `DECAY_SHIFT);
				envM[b] = (bpInt > decayed) ? bpInt : decayed;
			end
		end
	endfunction

	function automatic int bandPowerM(input int b);
		return enableM[b] ? envM[b] : 0;
	endfunction

	function automatic int litRows(input int b);
		int n;
		n = 0;
		for (int r = 0; r < `NUM_LEVELS; r++) begin
			if (bandPowerM(b) >= (r + 1) * `LEVEL_STEP) begin
				n++;
			end
		end
		return n;
	endfunction

	// green, green, green, yellow, yellow, red from the bottom
	function automatic logic [23:0] rowColour(input int r);
		if (r < 3) begin
			return 24'h00ff00;
		end else if (r < 5) begin
			return 24'hffff00;
		end
		return 24'hff0000;
	endfunction

	function automatic logic [23:0] expectColour(input int x, input int y);
		int left;
		int top;
		logic [23:0] c;
		c = 24'h000000;
		for (int b = 0; b < `NUM_BANDS; b++) begin
			for (int r = 0; r < `NUM_LEVELS; r++) begin
				left = `ORIGIN_X + b * `PITCH_X;
				top = `ORIGIN_Y + (`NUM_LEVELS - 1 - r) * `PITCH_Y;
				if (x >= left && x < left + `BLOCK_W && y >= top && y < top + `BLOCK_H
						&& bandPowerM(b) >= (r + 1) * `LEVEL_STEP) begin
					c = rowColour(r);
				end
			end
		end
		return c;
	endfunction

	always @(posedge clk) begin
		tagD1 <= pixTag;
		tagD2 <= tagD1;
	end

	// colour is stable at the falling edge
	always @(negedge clk) begin : compareColour
		expect_t e;
		if (tagD2) begin
			if (expQ.size() == 0) begin
				$display("a pixel result arrived at %0t with nothing expected", $time);
				errorCount++;
			end else begin
				e = expQ.pop_front();
				checkCount++;
				if (colour !== e.colour) begin
					$display("** Error at %0t ns: pixel (%0d,%0d) colour %h, expected %h",
						$time, e.x, e.y, colour, e.colour);
					errorCount++;
				end
			end
		end
	end

	task automatic presentPixel(input int x, input int y, input logic [23:0] want);
		expect_t e;
		e.x = 10'(x);
		e.y = 9'(y);
		e.colour = want;
		@(posedge clk);
		pixel.x <= 10'(x);
		pixel.y <= 9'(y);
		pixTag <= 1'b1;
		expQ.push_back(e);
	endtask

	task automatic drainScan();
		int waited;
		@(posedge clk);
		pixTag <= 1'b0;
		waited = 0;
		while (expQ.size() > 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() > 0) begin
			$display("pixel results stopped arriving, %0d still pending after %0d cycles",
				expQ.size(), DRAIN_LIMIT);
			errorCount++;
			timedOut = 1'b1;
		end
	endtask

	task automatic sendSample(input int l, input int r);
		@(posedge clk);
		sampleValid <= 1'b1;
		audioL <= 16'(l);
		audioR <= 16'(r);
		modelSample(l, r);
		@(posedge clk);
		sampleValid <= 1'b0;
	endtask

	// centre and two corners of every tile
	task automatic scanTiles();
		int left;
		int top;
		for (int b = 0; b < `NUM_BANDS; b++) begin
			for (int r = 0; r < `NUM_LEVELS; r++) begin
				left = `ORIGIN_X + b * `PITCH_X;
				top = `ORIGIN_Y + (`NUM_LEVELS - 1 - r) * `PITCH_Y;
				presentPixel(left + `BLOCK_W / 2, top + `BLOCK_H / 2,
					expectColour(left + `BLOCK_W / 2, top + `BLOCK_H / 2));
				presentPixel(left, top, expectColour(left, top));
				presentPixel(left + `BLOCK_W - 1, top + `BLOCK_H - 1,
					expectColour(left + `BLOCK_W - 1, top + `BLOCK_H - 1));
			end
		end
		drainScan();
	endtask

	task automatic resetDut();
		rstN <= 1'b0;
		for (int b = 0; b < `NUM_BANDS; b++) begin
			fastM[b] = 0;
			slowM[b] = 0;
			envM[b] = 0;
		end
		enableM = '1;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic silentScreen();
		for (int y = 0; y < 480; y += 8) begin
			for (int x = 0; x < 640; x += 8) begin
				presentPixel(x, y, 24'h000000);
			end
		end
		drainScan();
	endtask

	task automatic burstLevels();
		int l;
		int r;
		int lit;
		lit = 0;
		for (int i = 0; i < 200; i++) begin
			randomSample(l);
			randomSample(r);
			sendSample(l, r);
		end
		for (int b = 0; b < `NUM_BANDS; b++) begin
			$display("band %0d power %0d, %0d rows lit", b, envM[b], litRows(b));
			lit += litRows(b);
		end
		if (lit == 0) begin
			$display("the sample burst left every tile dark");
			errorCount++;
		end
		scanTiles();
	endtask

	task automatic gapsStayBlack();
		int edgeX;
		int edgeY;
		int gapEnd;
		// left margin and the column gaps, the last one runs to the screen edge
		for (int y = 0; y < 480; y += 7) begin
			presentPixel(0, y, 24'h000000);
			presentPixel(`ORIGIN_X - 1, y, 24'h000000);
			for (int b = 0; b < `NUM_BANDS; b++) begin
				edgeX = `ORIGIN_X + b * `PITCH_X + `BLOCK_W;
				presentPixel(edgeX, y, 24'h000000);
				presentPixel(edgeX + `PITCH_X - `BLOCK_W - 1, y, 24'h000000);
			end
		end
		// top margin and the row gaps
		for (int x = 0; x < 640; x += 9) begin
			presentPixel(x, 0, 24'h000000);
			presentPixel(x, `ORIGIN_Y - 1, 24'h000000);
			for (int r = 0; r < `NUM_LEVELS; r++) begin
				edgeY = `ORIGIN_Y + (`NUM_LEVELS - 1 - r) * `PITCH_Y + `BLOCK_H;
				gapEnd = edgeY + `PITCH_Y - `BLOCK_H - 1;
				if (gapEnd > 479) begin
					gapEnd = 479;
				end
				presentPixel(x, edgeY, 24'h000000);
				presentPixel(x, gapEnd, 24'h000000);
			end
		end
		drainScan();
	endtask

	task automatic bandDisable();
		int loud;
		loud = 0;
		for (int b = 1; b < `NUM_BANDS; b++) begin
			if (envM[b] > envM[loud]) begin
				loud = b;
			end
		end
		$display("disabling band %0d with %0d rows lit", loud, litRows(loud));
		@(posedge clk);
		bandEnable[loud] <= 1'b0;
		enableM[loud] = 1'b0;
		fastM[loud] = 0;
		slowM[loud] = 0;
		envM[loud] = 0;
		scanTiles();
	endtask

	task automatic zeroDecay();
		@(posedge clk);
		bandEnable <= '1;
		enableM = '1;
		for (int i = 0; i < 8; i++) begin
			sendSample(0, 0);
		end
		scanTiles();
		for (int i = 0; i < 40; i++) begin
			sendSample(0, 0);
		end
		for (int b = 0; b < `NUM_BANDS; b++) begin
			$display("band %0d decayed to %0d, %0d rows lit", b, envM[b], litRows(b));
		end
		scanTiles();
	endtask

	initial begin
		rstN = 1'b0;
		sampleValid = 1'b0;
		audioL = '0;
		audioR = '0;
		bandEnable = '1;
		pixel = '0;
		pixTag = 1'b0;
		lfsr = 16'd12118;
		resetDut();
		silentScreen();
		if (!timedOut) begin
			burstLevels();
		end
		if (!timedOut) begin
			gapsStayBlack();
		end
		if (!timedOut) begin
			bandDisable();
		end
		if (!timedOut) begin
			zeroDecay();
		end
		$display("pixel checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/spectrumPkg.sv
logic/bandPower.sv
logic/levelBlock.sv
logic/layerMixer.sv
logic/screenManager.sv
bench/screenManager_props.sv
bench/screenManager_tb.sv

//--- include/spectrum_defs.svh
`ifndef SPECTRUM_DEFS_SVH
`define SPECTRUM_DEFS_SVH

// grid size, one column per band
`define NUM_BANDS 6
`define NUM_LEVELS 6
`define NUM_LAYERS (`NUM_BANDS * `NUM_LEVELS)

// block size and spacing in pixels
`define BLOCK_W 95
`define BLOCK_H 69
`define PITCH_X 105
`define PITCH_Y 79

// top-left corner of the grid
`define ORIGIN_X 10
`define ORIGIN_Y 10

// band b uses fast shift b+FAST_SHIFT_BASE, slow shift adds SLOW_SHIFT_GAP
`define FAST_SHIFT_BASE 1
`define SLOW_SHIFT_GAP 2

// envelope loses env>>DECAY_SHIFT per sample
`define DECAY_SHIFT 4

// row r lights at (r+1)*LEVEL_STEP
`define LEVEL_STEP 128
`define POWER_W 11

`endif

//--- logic/bandPower.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_defs.svh"

module bandPower #(
	parameter int FAST_SHIFT = 1,
	parameter int SLOW_SHIFT = 3
) (
	input logic clk,
	input logic rstN,
	input logic enable,
	input logic sampleValid,
	input spectrumPkg::sample_t audioL,
	input spectrumPkg::sample_t audioR,
	output logic [`POWER_W-1:0] power
);
	import spectrumPkg::*;

	// fractional bits kept below the sample LSB in both filters
	localparam int FRAC_W = 8;
	localparam int ACC_W = $bits(sample_t) + FRAC_W;
	localparam logic [`POWER_W-1:0] POWER_MAX = '1;

	logic signed [$bits(sample_t):0] stereoSum;
	sample_t mono;
	logic signed [ACC_W-1:0] monoExt;

	logic signed [ACC_W-1:0] fastLp;
	logic signed [ACC_W-1:0] slowLp;
	logic signed [ACC_W-1:0] fastNext;
	logic signed [ACC_W-1:0] slowNext;
	logic signed [ACC_W:0] fastErr;
	logic signed [ACC_W:0] slowErr;

	logic signed [ACC_W:0] bandDiff;
	logic [ACC_W-1:0] bandMag;
	logic [ACC_W-FRAC_W-1:0] bandInt;
	logic [`POWER_W-1:0] bandSat;

	logic [`POWER_W-1:0] env;
	logic [`POWER_W-1:0] envDecay;
	logic [`POWER_W-1:0] envNext;

	// mono mix, (L+R)>>>1 is the sum without its LSB
	always_comb begin
		stereoSum = {audioL[$bits(sample_t)-1], audioL} + {audioR[$bits(sample_t)-1], audioR};
		mono = stereoSum[$bits(sample_t):1];
		monoExt = {mono, {FRAC_W{1'b0}}};
	end

	// two one-pole low-pass filters, the slow one sets the lower band edge
	always_comb begin
		fastErr = monoExt - fastLp;
		slowErr = monoExt - slowLp;
		fastNext = ACC_W'(fastLp + (fastErr >>> FAST_SHIFT));
		slowNext = ACC_W'(slowLp + (slowErr >>> SLOW_SHIFT));
	end

	// band-pass magnitude in whole sample units
	always_comb begin
		bandDiff = fastNext - slowNext;
		bandMag = bandDiff[ACC_W] ? ACC_W'(-bandDiff) : ACC_W'(bandDiff);
		bandInt = bandMag[ACC_W-1:FRAC_W];
		bandSat = (bandInt > POWER_MAX) ? POWER_MAX : bandInt[`POWER_W-1:0];
	end

	// leaky peak hold
	always_comb begin
		envDecay = env - (env >> `DECAY_SHIFT);
		envNext = (bandSat > envDecay) ? bandSat : envDecay;
	end

	// a disabled band holds its whole state at zero
	always_ff @(posedge clk) begin
		if (!rstN || !enable) begin
			fastLp <= '0;
			slowLp <= '0;
			env <= '0;
		end else if (sampleValid) begin
			fastLp <= fastNext;
			slowLp <= slowNext;
			env <= envNext;
		end
	end

	assign power = enable ? env : '0;

endmodule

`default_nettype wire

//--- logic/layerMixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_defs.svh"

module layerMixer (
	input logic clk,
	input logic rstN,
	input spectrumPkg::layerPix_t layers [`NUM_LAYERS],
	output spectrumPkg::rgb_t colour
);
	import spectrumPkg::*;

	localparam int IDX_W = $clog2(`NUM_LAYERS);

	logic anyHit;
	logic [IDX_W-1:0] hitIdx;
	rgb_t pickedColour;

	// priority encoder, highest valid index wins
	// later loop passes override earlier ones
	always_comb begin
		anyHit = 1'b0;
		hitIdx = '0;
		for (int i = 0; i < `NUM_LAYERS; i++) begin
			if (layers[i].valid) begin
				anyHit = 1'b1;
				hitIdx = IDX_W'(i);
			end
		end
	end

	// background is black
	always_comb begin
		if (anyHit) begin
			pickedColour = layers[hitIdx].colour;
		end else begin
			pickedColour = BLACK;
		end
	end

	// output register, second stage of the pixel pipeline
	always_ff @(posedge clk) begin
		if (!rstN) begin
			colour <= BLACK;
		end else begin
			colour <= pickedColour;
		end
	end

endmodule

`default_nettype wire

//--- logic/levelBlock.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_defs.svh"

module levelBlock #(
	parameter int BAND = 0,
	parameter int LEVEL = 0
) (
	input logic clk,
	input logic rstN,
	input spectrumPkg::pixelPos_t pixel,
	input logic [`POWER_W-1:0] power,
	output spectrumPkg::layerPix_t layer
);
	import spectrumPkg::*;

	// rectangle of this tile, row 0 sits at the bottom of the grid
	localparam int LEFT = `ORIGIN_X + BAND * `PITCH_X;
	localparam int TOP = `ORIGIN_Y + (`NUM_LEVELS - 1 - LEVEL) * `PITCH_Y;

	localparam logic [9:0] X_LO = 10'(LEFT);
	localparam logic [9:0] X_HI = 10'(LEFT + `BLOCK_W);
	localparam logic [8:0] Y_LO = 9'(TOP);
	localparam logic [8:0] Y_HI = 9'(TOP + `BLOCK_H);

	// power needed before this row lights
	localparam logic [`POWER_W-1:0] THRESHOLD = `POWER_W'((LEVEL + 1) * `LEVEL_STEP);

	// green for the lower half, yellow above it, red on top
	localparam rgb_t ROW_COLOUR = (LEVEL < 3) ? GREEN : (LEVEL < 5) ? YELLOW : RED;

	logic insideX;
	logic insideY;
	logic aboveThreshold;
	logic litNext;
	logic litQ;

	// upper bounds are exclusive
	always_comb begin
		insideX = (pixel.x >= X_LO) && (pixel.x < X_HI);
		insideY = (pixel.y >= Y_LO) && (pixel.y < Y_HI);
	end

	assign aboveThreshold = (power >= THRESHOLD);
	assign litNext = insideX && insideY && aboveThreshold;

	// one cycle from pixel to layer
	always_ff @(posedge clk) begin
		if (!rstN) begin
			litQ <= 1'b0;
		end else begin
			litQ <= litNext;
		end
	end

	// the colour is fixed per row, only valid moves
	always_comb begin
		layer.valid = litQ;
		layer.colour = ROW_COLOUR;
	end

endmodule

`default_nettype wire

//--- logic/screenManager.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_defs.svh"

module screenManager (
	input logic clk,
	input logic rstN,

	// audio side, one strobe per stereo sample
	input logic sampleValid,
	input spectrumPkg::sample_t audioL,
	input spectrumPkg::sample_t audioR,
	input logic [`NUM_BANDS-1:0] bandEnable,

	// raster side
	input spectrumPkg::pixelPos_t pixel,
	output spectrumPkg::rgb_t colour
);
	import spectrumPkg::*;

	logic [`POWER_W-1:0] power [`NUM_BANDS];
	layerPix_t layers [`NUM_LAYERS];

	for (genvar b = 0; b < `NUM_BANDS; b++) begin : bandGen
		// higher bands get longer filter time constants
		bandPower #(
			.FAST_SHIFT(b + `FAST_SHIFT_BASE),
			.SLOW_SHIFT(b + `FAST_SHIFT_BASE + `SLOW_SHIFT_GAP)
		) bandPower_inst (
			.clk(clk),
			.rstN(rstN),
			.enable(bandEnable[b]),
			.sampleValid(sampleValid),
			.audioL(audioL),
			.audioR(audioR),
			.power(power[b])
		);

		// one column of tiles per band, index b*NUM_LEVELS+r
		for (genvar r = 0; r < `NUM_LEVELS; r++) begin : levelGen
			levelBlock #(
				.BAND(b),
				.LEVEL(r)
			) levelBlock_inst (
				.clk(clk),
				.rstN(rstN),
				.pixel(pixel),
				.power(power[b]),
				.layer(layers[b * `NUM_LEVELS + r])
			);
		end
	end

	layerMixer layerMixer_inst (
		.clk(clk),
		.rstN(rstN),
		.layers(layers),
		.colour(colour)
	);

endmodule

`default_nettype wire

//--- logic/spectrumPkg.sv
`default_nettype none

package spectrumPkg;

	// raster position, 640x480 fits in 10 by 9 bits
	typedef struct packed {
		logic [9:0] x;
		logic [8:0] y;
	} pixelPos_t;

	// 24-bit colour
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// one display layer for the current pixel
	typedef struct packed {
		logic valid;
		rgb_t colour;
	} layerPix_t;

	// signed audio sample, one channel
	typedef logic signed [15:0] sample_t;

	// the display palette
	localparam rgb_t BLACK = '{r: 8'd0, g: 8'd0, b: 8'd0};
	localparam rgb_t GREEN = '{r: 8'd0, g: 8'd255, b: 8'd0};
	localparam rgb_t YELLOW = '{r: 8'd255, g: 8'd255, b: 8'd0};
	localparam rgb_t RED = '{r: 8'd255, g: 8'd0, b: 8'd0};

endpackage

`default_nettype wire
